// ==== npu_pkg.sv ====
package npu_pkg;

    // bus geometry
    localparam int data_w = 32;
    localparam int addr_w = 16;
    localparam int strb_w = data_w / 8;
    localparam int word_w = addr_w - 2;

    localparam int cfg_words = 32;
    localparam int mem_words = 64;
    localparam int cfg_aw    = $clog2(cfg_words);
    localparam int mem_aw    = $clog2(mem_words);
    localparam int ctrl_aw   = 4;                   // 16 control slots

    // byte address map, core config below cfg_base reads zero
    localparam logic [addr_w-1:0] cfg_base  = 16'h0200;
    localparam logic [addr_w-1:0] ctrl_base = 16'h0300;
    localparam logic [addr_w-1:0] mem_base  = 16'h0400;

    localparam logic [word_w-1:0] cfg_wbase  = cfg_base[addr_w-1:2];
    localparam logic [word_w-1:0] ctrl_wbase = ctrl_base[addr_w-1:2];
    localparam logic [word_w-1:0] mem_wbase  = mem_base[addr_w-1:2];

    // config word indexes
    localparam int cfg_range      = 1;    // wl st, wl end, bl st, bl end
    localparam int cfg_static     = 4;
    localparam int cfg_width_sr   = 5;    // set width low half, reset width high half
    localparam int cfg_op_list    = 14;
    localparam int cfg_loops      = 16;
    localparam int cfg_width_read = 17;

    // control word indexes
    localparam int ctrl_start  = 0;
    localparam int ctrl_stop   = 1;
    localparam int ctrl_status = 2;

    typedef enum logic [1:0] {
        op_set   = 2'd0,
        op_reset = 2'd1,
        op_read  = 2'd2,
        op_skip  = 2'd3
    } op_t;

    typedef struct packed {
        logic              awvalid;
        logic [addr_w-1:0] awaddr;
        logic              wvalid;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
        logic              bready;
        logic              arvalid;
        logic [addr_w-1:0] araddr;
        logic              rready;
    } axil_m2s_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [data_w-1:0] rdata;
        logic [1:0]        rresp;
    } axil_s2m_t;

    typedef struct packed {
        logic              valid;
        logic [word_w-1:0] word;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } reg_wr_t;

    typedef struct packed {
        logic [7:0]      wl_st;
        logic [7:0]      wl_end;
        logic [7:0]      bl_st;
        logic [7:0]      bl_end;
        op_t [7:0]       ops;
        logic [2:0]      op_cnt;        // number of ops minus one
        logic [31:0]     loops;
        logic [15:0]     width_set;
        logic [15:0]     width_reset;
        logic [15:0]     width_read;
    } scan_cfg_t;

    typedef struct packed {
        logic        valid;
        op_t         op;
        logic [15:0] width;
    } pulse_req_t;

    typedef struct packed {
        logic       valid;
        logic [5:0] data;
    } sample_t;

    typedef struct packed {
        logic [8:0] addr;
        logic [7:0] din;
        logic       set;
        logic       reset;
        logic       clkadc;
        logic       dacwl_sw;
        logic       dacbl_sw;
        logic       dacsel_sw;
    } array_drive_t;

    typedef struct packed {
        logic dischg;
        logic arst_enreg;
        logic arst_wlreg;
        logic aset_enreg;
        logic aset_wlreg;
    } array_static_t;

endpackage

// ==== npu_axil_slave.sv ====
module npu_axil_slave
    import npu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  axil_m2s_t         bus,
    output axil_s2m_t         rsp,
    output reg_wr_t           reg_wr,
    output logic [word_w-1:0] rd_word,
    input  logic [data_w-1:0] rd_data
);

    logic              b_pend;
    logic              r_pend;
    logic [data_w-1:0] rdata_q;
    logic              wr_take;
    logic              rd_take;

    logic              wr_valid;
    logic [word_w-1:0] wr_word;
    logic [data_w-1:0] wr_data;
    logic [strb_w-1:0] wr_strb;

    // aw and w only go together, one transfer per response
    assign wr_take = bus.awvalid && bus.wvalid && !b_pend;
    assign rd_take = bus.arvalid && !r_pend;

    assign rd_word = bus.araddr[addr_w-1:2];    // byte to word

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_pend <= 1'b0;
        end else if (wr_take) begin
            b_pend <= 1'b1;
        end else if (bus.bready) begin
            b_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_pend <= 1'b0;
        end else if (rd_take) begin
            r_pend <= 1'b1;
        end else if (bus.rready) begin
            r_pend <= 1'b0;
        end
    end

    // held until rready since r_pend blocks a new capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (rd_take) begin
            rdata_q <= rd_data;
        end
    end

    // write lands in the register file one edge after the handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= wr_take;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_word <= '0;
            wr_data <= '0;
            wr_strb <= '0;
        end else if (wr_take) begin
            wr_word <= bus.awaddr[addr_w-1:2];
            wr_data <= bus.wdata;
            wr_strb <= bus.wstrb;
        end
    end

    always_comb begin
        reg_wr.valid = wr_valid;
        reg_wr.word  = wr_word;
        reg_wr.data  = wr_data;
        reg_wr.strb  = wr_strb;
    end

    always_comb begin
        rsp.awready = wr_take;
        rsp.wready  = wr_take;
        rsp.bvalid  = b_pend;
        rsp.bresp   = 2'b00;    // always okay
        rsp.arready = !r_pend;
        rsp.rvalid  = r_pend;
        rsp.rdata   = rdata_q;
        rsp.rresp   = 2'b00;
    end

endmodule

// ==== npu_regfile.sv ====
module npu_regfile
    import npu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  reg_wr_t           reg_wr,
    input  logic [word_w-1:0] rd_word,
    output logic [data_w-1:0] rd_data,
    input  logic              busy,
    input  sample_t           sample,
    output scan_cfg_t         cfg,
    output array_static_t     static_pins,
    output logic              start,
    output logic              stop
);

    logic [data_w-1:0] cfg_q [cfg_words];
    logic [5:0]        mem_q [mem_words];     // raw adc codes
    logic [mem_aw-1:0] wr_ptr;
    logic [6:0]        smp_cnt;

    logic              wr_cfg_hit;
    logic              wr_ctrl_hit;
    logic [cfg_aw-1:0] wr_cfg_idx;
    logic [15:0]       read_w_raw;

    assign wr_cfg_hit  = reg_wr.valid && (reg_wr.word[word_w-1:cfg_aw] == cfg_wbase[word_w-1:cfg_aw]);
    assign wr_ctrl_hit = reg_wr.valid
                         && (reg_wr.word[word_w-1:ctrl_aw] == ctrl_wbase[word_w-1:ctrl_aw]);
    assign wr_cfg_idx  = reg_wr.word[cfg_aw-1:0];

    // command strobes, one cycle since reg_wr.valid is
    assign start = wr_ctrl_hit && (reg_wr.word[ctrl_aw-1:0] == ctrl_aw'(ctrl_start))
                   && reg_wr.strb[0] && reg_wr.data[0];
    assign stop  = wr_ctrl_hit && (reg_wr.word[ctrl_aw-1:0] == ctrl_aw'(ctrl_stop))
                   && reg_wr.strb[0] && reg_wr.data[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cfg_words; i++) begin
                cfg_q[i] <= '0;
            end
        end else if (wr_cfg_hit) begin
            for (int b = 0; b < strb_w; b++) begin
                if (reg_wr.strb[b]) begin
                    cfg_q[wr_cfg_idx][8*b +: 8] <= reg_wr.data[8*b +: 8];
                end
            end
        end
    end

    // sample pointer and count, start rewinds
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            smp_cnt <= '0;
        end else if (start) begin
            wr_ptr  <= '0;
            smp_cnt <= '0;
        end else if (sample.valid) begin
            wr_ptr <= wr_ptr + 1'b1;             // wraps at 64
            if (smp_cnt != 7'(mem_words)) begin
                smp_cnt <= smp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample.valid && !start) begin
            mem_q[wr_ptr] <= sample.data;
        end
    end

    always_comb begin
        rd_data = '0;                              // unmapped and core config
        if (rd_word[word_w-1:cfg_aw] == cfg_wbase[word_w-1:cfg_aw]) begin
            rd_data = cfg_q[rd_word[cfg_aw-1:0]];
        end else if (rd_word[word_w-1:mem_aw] == mem_wbase[word_w-1:mem_aw]) begin
            rd_data = {26'd0, mem_q[rd_word[mem_aw-1:0]]};
        end else if (rd_word == ctrl_wbase + word_w'(ctrl_status)) begin
            rd_data = {9'd0, smp_cnt, 15'd0, busy};
        end
    end

    assign read_w_raw = cfg_q[cfg_width_read][15:0];

    always_comb begin
        cfg.wl_st  = cfg_q[cfg_range][7:0];
        cfg.wl_end = cfg_q[cfg_range][15:8];
        cfg.bl_st  = cfg_q[cfg_range][23:16];
        cfg.bl_end = cfg_q[cfg_range][31:24];
        for (int i = 0; i < 8; i++) begin
            cfg.ops[i] = op_t'(cfg_q[cfg_op_list][2*i +: 2]);
        end
        cfg.op_cnt      = cfg_q[cfg_op_list][18:16];
        cfg.loops       = cfg_q[cfg_loops];
        cfg.width_set   = cfg_q[cfg_width_sr][15:0];
        cfg.width_reset = cfg_q[cfg_width_sr][31:16];
        cfg.width_read  = (read_w_raw > 16'd1) ? read_w_raw : 16'd1;
    end

    always_comb begin
        static_pins.dischg     = cfg_q[cfg_static][0];
        static_pins.arst_enreg = cfg_q[cfg_static][1];
        static_pins.arst_wlreg = cfg_q[cfg_static][2];
        static_pins.aset_enreg = cfg_q[cfg_static][3];
        static_pins.aset_wlreg = cfg_q[cfg_static][4];
    end

endmodule

// ==== npu_scan_seq.sv ====
module npu_scan_seq
    import npu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  scan_cfg_t  cfg,
    input  logic       start,
    input  logic       stop,
    output logic       busy,
    output pulse_req_t req,
    input  logic       idle,
    input  logic       done,
    output logic [7:0] wl,
    output logic [7:0] bl
);

    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_wait,
        s_next
    } state_t;

    state_t      state;
    logic [2:0]  op_pos;
    logic [31:0] loop_cnt;
    op_t         cur_op;

    assign cur_op = cfg.ops[op_pos];
    assign busy   = (state != s_idle);

    // stop blocks an accept in the same cycle
    always_comb begin
        req.valid = (state == s_issue) && (cur_op != op_skip) && !stop;
        req.op    = cur_op;
        case (cur_op)
            op_set:   req.width = cfg.width_set;
            op_reset: req.width = cfg.width_reset;
            default:  req.width = cfg.width_read;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= s_idle;
            op_pos   <= '0;
            loop_cnt <= '0;
            wl       <= '0;
            bl       <= '0;
        end else if (stop) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        wl       <= cfg.wl_st;
                        bl       <= cfg.bl_st;
                        op_pos   <= '0;
                        loop_cnt <= '0;
                        if (cfg.loops != 32'd0) begin
                            state <= s_issue;
                        end
                    end
                end
                s_issue: begin
                    if (cur_op == op_skip) begin
                        state <= s_next;
                    end else if (idle) begin
                        state <= s_wait;        // request taken
                    end
                end
                s_wait: begin
                    if (done) begin
                        state <= s_next;
                    end
                end
                s_next: begin
                    state <= s_issue;
                    if (op_pos != cfg.op_cnt) begin
                        op_pos <= op_pos + 1'b1;
                    end else begin
                        op_pos <= '0;
                        if (bl != cfg.bl_end) begin
                            bl <= bl + 1'b1;    // bit line inner
                        end else begin
                            bl <= cfg.bl_st;
                            if (wl != cfg.wl_end) begin
                                wl <= wl + 1'b1;
                            end else begin
                                wl <= cfg.wl_st;
                                // whole rectangle done
                                if (loop_cnt == cfg.loops - 32'd1) begin
                                    state <= s_idle;
                                end else begin
                                    loop_cnt <= loop_cnt + 32'd1;
                                end
                            end
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// ==== npu_pulse_gen.sv ====
module npu_pulse_gen
    import npu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  pulse_req_t   req,
    output logic         idle,
    output logic         done,
    input  logic [7:0]   wl,
    input  logic [7:0]   bl,
    input  logic [5:0]   dout,
    output array_drive_t drive,
    output sample_t      sample
);

    logic        active;
    logic [15:0] cnt;          // cycles left after this one
    logic        last;
    op_t         op_q;
    logic [7:0]  wl_q;
    logic [7:0]  bl_q;
    logic        smp_valid;
    logic [5:0]  smp_data;

    assign idle = !active;
    assign last = active && (cnt == 16'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            cnt       <= '0;
            done      <= 1'b0;
            smp_valid <= 1'b0;
        end else begin
            done      <= last;
            smp_valid <= last && (op_q == op_read);
            if (req.valid && !active) begin
                active <= 1'b1;
                cnt    <= (req.width == 16'd0) ? 16'd0 : req.width - 16'd1;  // zero acts as one
            end else if (last) begin
                active <= 1'b0;
            end else if (active) begin
                cnt <= cnt - 16'd1;
            end
        end
    end

    // array address stays put between pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wl_q <= '0;
            bl_q <= '0;
        end else if (req.valid && !active) begin
            wl_q <= wl;
            bl_q <= bl;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q     <= op_set;
            smp_data <= '0;
        end else begin
            if (req.valid && !active) begin
                op_q <= req.op;
            end
            if (last && (op_q == op_read)) begin
                smp_data <= dout;       // adc edge
            end
        end
    end

    always_comb begin
        sample.valid = smp_valid;
        sample.data  = smp_data;
    end

    always_comb begin
        drive.addr      = {1'b0, wl_q};
        drive.din       = bl_q;
        drive.set       = active && (op_q == op_set);
        drive.reset     = active && (op_q == op_reset);
        drive.clkadc    = last && (op_q == op_read);
        drive.dacwl_sw  = active;
        drive.dacsel_sw = active;
        drive.dacbl_sw  = active && ((op_q == op_set) || (op_q == op_read));
    end

endmodule

// ==== npu_wrap.sv ====
module npu_wrap
    import npu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  axil_m2s_t     bus,
    output axil_s2m_t     rsp,
    input  logic [5:0]    dout,
    output array_drive_t  drive,
    output array_static_t static_pins
);

    reg_wr_t           reg_wr;
    logic [word_w-1:0] rd_word;
    logic [data_w-1:0] rd_data;
    scan_cfg_t         cfg;
    logic              start;
    logic              stop;
    logic              busy;
    pulse_req_t        req;
    logic              idle;
    logic              done;
    logic [7:0]        wl;
    logic [7:0]        bl;
    sample_t           sample;

    npu_axil_slave u_axil (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus),
        .rsp     (rsp),
        .reg_wr  (reg_wr),
        .rd_word (rd_word),
        .rd_data (rd_data)
    );

    npu_regfile u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .rd_word     (rd_word),
        .rd_data     (rd_data),
        .busy        (busy),
        .sample      (sample),
        .cfg         (cfg),
        .static_pins (static_pins),
        .start       (start),
        .stop        (stop)
    );

    npu_scan_seq u_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .start (start),
        .stop  (stop),
        .busy  (busy),
        .req   (req),
        .idle  (idle),
        .done  (done),
        .wl    (wl),
        .bl    (bl)
    );

    npu_pulse_gen u_pulse (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .idle   (idle),
        .done   (done),
        .wl     (wl),
        .bl     (bl),
        .dout   (dout),
        .drive  (drive),
        .sample (sample)
    );

endmodule

// ==== tb_npu_checker.sv ====
module tb_npu_checker
    import npu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  axil_m2s_t    bus,
    input  axil_s2m_t    rsp,
    input  array_drive_t drive,
    input  logic         clear,
    input  logic [31:0]  range_word,
    input  logic [31:0]  width_word,
    output int           set_cnt,
    output int           reset_cnt,
    output int           pin_errors,
    output int           value_errors
);

    int                set_run;
    int                reset_run;
    int                stop_age;      // cycles since the stop write, -1 when none
    int                row;
    int                rows;
    logic              set_q;
    logic              reset_q;
    logic              pulse_q;
    logic              adc_q;
    logic              read_q;
    logic              bv_q;
    logic              br_q;
    logic              rv_q;
    logic              rr_q;
    logic [data_w-1:0] rdata_q;

    function automatic int eff_width(input logic [15:0] w);
        return (w == 16'd0) ? 1 : int'(w);
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_pin(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
            pin_errors++;
        end
    endtask

    task automatic bus_error(input string what);
        $display("bus rule broken: %s", what);
        pin_errors++;
    endtask

    task automatic pin_rule(input string what);
        $display("array pin rule broken: %s", what);
        pin_errors++;
    endtask

    always @(negedge clk) begin
        if (!rst_n || clear) begin
            set_cnt   = 0;
            reset_cnt = 0;
            set_run   = 0;
            reset_run = 0;
            stop_age  = -1;
            set_q     = 1'b0;
            reset_q   = 1'b0;
            pulse_q   = 1'b0;
            adc_q     = 1'b0;
            read_q    = 1'b0;
            bv_q      = 1'b0;
            br_q      = 1'b0;
            rv_q      = 1'b0;
            rr_q      = 1'b0;
        end else begin
            if (drive.set) begin
                if (!set_q) begin
                    // word lines outer, bit lines inner
                    row  = int'(range_word[31:24]) - int'(range_word[23:16]) + 1;
                    rows = int'(range_word[15:8]) - int'(range_word[7:0]) + 1;
                    check_pin("set_wl", int'(range_word[7:0]) + (set_cnt / row) % rows,
                              int'(drive.addr));
                    check_pin("set_bl", int'(range_word[23:16]) + set_cnt % row,
                              int'(drive.din));
                    set_cnt++;
                end
                set_run++;
            end else if (set_q) begin
                check_pin("set_width", eff_width(width_word[15:0]), set_run);
                set_run = 0;
            end
            if (drive.reset) begin
                if (!reset_q) begin
                    reset_cnt++;
                end
                reset_run++;
            end else if (reset_q) begin
                check_pin("reset_width", eff_width(width_word[31:16]), reset_run);
                reset_run = 0;
            end

            // switch and adc pins against the pulse type
            if (drive.dacsel_sw !== drive.dacwl_sw) pin_rule("dacsel_sw differs from dacwl_sw");
            if ((drive.set || drive.reset || drive.clkadc) && !drive.dacwl_sw) begin
                pin_rule("strobe outside a pulse");
            end
            if (drive.set && drive.reset) pin_rule("set and reset together");
            if (drive.dacwl_sw && (drive.dacbl_sw !== !drive.reset)) begin
                pin_rule("dacbl_sw wrong for the pulse type");
            end
            if (drive.clkadc && (drive.set || drive.reset)) pin_rule("clkadc in a set or reset");
            if (adc_q && drive.dacwl_sw) pin_rule("clkadc not in the last pulse cycle");
            if (read_q && !drive.dacwl_sw && !adc_q) pin_rule("read pulse ended without clkadc");

            if (stop_age >= 0) begin
                stop_age++;
            end
            if (bus.awvalid && rsp.awready && bus.awaddr == ctrl_base + 16'(4 * ctrl_stop)
                && bus.wstrb[0] && bus.wdata[0]) begin
                stop_age = 0;
            end
            if (stop_age >= 3 && drive.dacwl_sw && !pulse_q) begin
                $display("a pulse started %0d cycles after the stop write", stop_age);
                pin_errors++;
            end

            if (bv_q && !br_q && !rsp.bvalid) bus_error("bvalid dropped before bready");
            if (rsp.bvalid && bus.awvalid && rsp.awready) bus_error("write taken while pending");
            if (rv_q && !rr_q && (!rsp.rvalid || rsp.rdata !== rdata_q)) begin
                bus_error("read response changed before rready");
            end
            if (rsp.rvalid && bus.arvalid && rsp.arready) bus_error("read taken while pending");
            if ((rsp.bvalid && rsp.bresp != 2'b00) || (rsp.rvalid && rsp.rresp != 2'b00)) begin
                bus_error("response is not OKAY");
            end

            set_q   = drive.set;
            reset_q = drive.reset;
            pulse_q = drive.dacwl_sw;
            adc_q   = drive.clkadc;
            read_q  = drive.dacwl_sw && !drive.set && !drive.reset;
            bv_q    = rsp.bvalid;
            br_q    = bus.bready;
            rv_q    = rsp.rvalid;
            rr_q    = bus.rready;
            rdata_q = rsp.rdata;
        end
    end

endmodule

// ==== tb_npu_wrap.sv ====
module tb_npu_wrap
    import npu_pkg::*;
();

    typedef struct packed {
        logic [4:0]  idx;
        logic [31:0] data;
    } cfg_wr_t;

    localparam int n_tests = 3;
    localparam int n_wr    = 5;     // range, op list, loops, set/reset width, read width
    localparam logic [15:0] status_addr = ctrl_base + 16'(4 * ctrl_status);

    logic          clk;
    logic          rst_n;
    axil_m2s_t     bus;
    axil_s2m_t     rsp;
    logic [5:0]    dout;
    array_drive_t  drive;
    array_static_t static_pins;

    logic        clear;
    logic [31:0] range_word;
    logic [31:0] width_word;
    int          set_cnt;
    int          reset_cnt;
    int          pin_errors;
    int          value_errors;
    int unsigned seed;

    string   t_name  [n_tests];
    cfg_wr_t t_wr    [n_tests][n_wr];
    int      t_set   [n_tests];     // -1 when it depends on when stop lands
    int      t_reset [n_tests];
    int      t_smp   [n_tests];
    bit      t_stop  [n_tests];

    npu_wrap dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .rsp         (rsp),
        .dout        (dout),
        .drive       (drive),
        .static_pins (static_pins)
    );

    tb_npu_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus),
        .rsp          (rsp),
        .drive        (drive),
        .clear        (clear),
        .range_word   (range_word),
        .width_word   (width_word),
        .set_cnt      (set_cnt),
        .reset_cnt    (reset_cnt),
        .pin_errors   (pin_errors),
        .value_errors (value_errors)
    );

    // array model
    assign dout = 6'((3 * int'(drive.addr) + int'(drive.din)) % 64);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("errors: %0d pin, %0d value, 1 timeout", pin_errors, value_errors);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic add_row(input int t, input string name, input logic [31:0] rng,
                           input logic [31:0] ops, input logic [31:0] loops,
                           input logic [31:0] wsr, input logic [31:0] wrd,
                           input int n_set, input int n_reset, input int n_smp, input bit stop);
        t_name[t]  = name;
        t_wr[t][0] = {5'(cfg_range), rng};
        t_wr[t][1] = {5'(cfg_op_list), ops};
        t_wr[t][2] = {5'(cfg_loops), loops};
        t_wr[t][3] = {5'(cfg_width_sr), wsr};
        t_wr[t][4] = {5'(cfg_width_read), wrd};
        t_set[t]   = n_set;
        t_reset[t] = n_reset;
        t_smp[t]   = n_smp;
        t_stop[t]  = stop;
    endtask

    // all bus tasks start and end 1 unit after a rising edge
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        n = 0;
        bus.awvalid = 1'b1;
        bus.awaddr  = addr;
        bus.wvalid  = 1'b1;
        bus.wdata   = data;
        bus.wstrb   = strb;
        @(negedge clk);
        while (!rsp.awready) begin
            n++;
            if (n > 20) fail_timeout("awready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        // aw and w stay up as a next transfer the slave must refuse
        repeat (int'(next_rand() % 4)) begin
            @(posedge clk);
            #1;
        end
        bus.bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rsp.bvalid) begin
            n++;
            if (n > 20) fail_timeout("bvalid");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        bus.bready  = 1'b0;
        bus.awvalid = 1'b0;
        bus.wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        bus.arvalid = 1'b1;
        bus.araddr  = addr;
        @(negedge clk);
        while (!rsp.arready) begin
            n++;
            if (n > 20) fail_timeout("arready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        repeat (int'(next_rand() % 4)) begin
            @(posedge clk);
            #1;
        end
        bus.rready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rsp.rvalid) begin
            n++;
            if (n > 20) fail_timeout("rvalid");
            @(negedge clk);
        end
        data = rsp.rdata;
        @(posedge clk);
        #1;
        bus.rready  = 1'b0;
        bus.arvalid = 1'b0;
    endtask

    task automatic write_cfg(input int idx, input logic [31:0] data);
        axil_write(cfg_base + 16'(4 * idx), data, 4'hf);
    endtask

    task automatic wait_set_pulses(input int target);
        int n;
        n = 0;
        while (set_cnt < target) begin
            n++;
            if (n > 500) fail_timeout("set pulses before stop");
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          n;
        n = 0;
        axil_read(status_addr, st);
        while (st[0]) begin
            n++;
            if (n > 400) fail_timeout("busy to fall");
            axil_read(status_addr, st);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] sw;
        logic [31:0] exp;
        int          row;
        int          cells;
        int          c;
        seed       = 15763;
        bus        = '0;
        rst_n      = 1'b0;
        clear      = 1'b0;
        range_word = '0;
        width_word = '0;
        //      t  name         range          op list        loops wset/wreset   wread set rst smp stop
        add_row(0, "set_reset", 32'h0100_0201, 32'h0002_0034, 1, 32'h0005_0003, 0, 4, 4, 0, 0);
        add_row(1, "read_scan", 32'h0403_0200, 32'h0000_0002, 2, 32'h0000_0000, 2, 0, 0, 12, 0);
        add_row(2, "stop_mid", 32'h0700_0700, 32'h0000_0000, 100, 32'h0000_0004, 0, -1, 0, 0, 1);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        axil_write(cfg_base + 16'd12, 32'h1122_3344, 4'hf);
        axil_write(cfg_base + 16'd12, 32'haabb_ccdd, 4'b0101);
        axil_write(cfg_base + 16'd36, 32'h5a5a_5a5a, 4'b1000);
        axil_write(16'h0900, 32'hffff_ffff, 4'hf);     // unmapped, dropped
        axil_read(cfg_base + 16'd12, rd);
        chk.check_word("cfg3_strobes", 32'h11bb_33dd, rd);
        axil_read(cfg_base + 16'd36, rd);
        chk.check_word("cfg9_strobes", 32'h5a00_0000, rd);
        axil_read(16'h0040, rd);
        chk.check_word("core_cfg_zero", 32'h0, rd);
        axil_read(16'h0900, rd);
        chk.check_word("unmapped_zero", 32'h0, rd);

        sw = 32'h0000_0016;
        write_cfg(cfg_static, sw);
        exp = {27'd0, sw[0], sw[1], sw[2], sw[3], sw[4]};  // dischg is bit 0 of the word
        chk.check_word("static_pins", exp, {27'd0, static_pins});

        for (int t = 0; t < n_tests; t++) begin
            clear      = 1'b1;
            range_word = t_wr[t][0].data;
            width_word = t_wr[t][3].data;
            @(posedge clk);
            #1;
            clear = 1'b0;
            for (int i = 0; i < n_wr; i++) begin
                write_cfg(int'(t_wr[t][i].idx), t_wr[t][i].data);
            end
            axil_write(ctrl_base + 16'(4 * ctrl_start), 32'd1, 4'hf);
            if (t_stop[t]) begin
                wait_set_pulses(3);
                axil_write(ctrl_base + 16'(4 * ctrl_stop), 32'd1, 4'hf);
            end
            axil_read(status_addr, rd);
            chk.check_word($sformatf("%s_busy", t_name[t]), {31'd0, !t_stop[t]}, {31'd0, rd[0]});
            wait_idle();
            repeat (20) @(posedge clk);                 // a pulse in flight may still close
            #1;
            axil_read(status_addr, rd);
            chk.check_word($sformatf("%s_status", t_name[t]), {9'd0, 7'(t_smp[t]), 16'd0}, rd);
            if (t_set[t] >= 0) begin
                chk.check_word($sformatf("%s_sets", t_name[t]), 32'(t_set[t]), 32'(set_cnt));
            end
            chk.check_word($sformatf("%s_resets", t_name[t]), 32'(t_reset[t]), 32'(reset_cnt));
            row   = int'(range_word[31:24]) - int'(range_word[23:16]) + 1;
            cells = row * (int'(range_word[15:8]) - int'(range_word[7:0]) + 1);
            for (int i = 0; i < t_smp[t]; i++) begin
                c   = i % cells;
                exp = 32'((3 * (int'(range_word[7:0]) + c / row)
                          + int'(range_word[23:16]) + c % row) % 64);
                axil_read(mem_base + 16'(4 * i), rd);
                chk.check_word($sformatf("%s_mem%0d", t_name[t], i), exp, rd);
            end
        end

        $display("errors: %0d pin, %0d value, 0 timeout", pin_errors, value_errors);
        if (pin_errors + value_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
npu_pkg.sv
npu_axil_slave.sv
npu_regfile.sv
npu_scan_seq.sv
npu_pulse_gen.sv
npu_wrap.sv
tb_npu_checker.sv
tb_npu_wrap.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_npu_wrap
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
